//--- rtl/cache_line_pkg.sv
package cache_line_pkg;

	// Line address, byte offset already stripped by the cache
	localparam int LINE_ADDR_W = 16;

	// One full cache line, eight 16 bit words
	localparam int LINE_DATA_W = 128;

	typedef logic [LINE_ADDR_W-1:0] line_addr_t;	// Address of one line in memory
	typedef logic [LINE_DATA_W-1:0] line_data_t;	// Whole line payload

endpackage : cache_line_pkg

//--- rtl/flow_pkg.sv
package flow_pkg;

	localparam int REQ_DEPTH = 4;		// Request queue entries, also sender credits after reset
	localparam int RESP_DEPTH = 4;		// Response queue entries
	localparam int RESP_CREDITS = 2;	// Consumer credits held after reset

	// Pointer widths, depths are powers of two so pointers wrap by themselves
	localparam int REQ_PTR_W = $clog2(REQ_DEPTH);
	localparam int RESP_PTR_W = $clog2(RESP_DEPTH);

	// Counter must hold the larger depth as well as zero
	localparam int CREDIT_W = $clog2((REQ_DEPTH > RESP_DEPTH) ? REQ_DEPTH : RESP_DEPTH) + 1;

	typedef logic [CREDIT_W-1:0] credit_cnt_t;	// Credit or occupancy count

endpackage : flow_pkg

//--- rtl/request_queue.sv
`timescale 1ns/1ps

module request_queue
(
	input logic clk,
	input logic reset,
	input logic req_valid,
	input logic req_write,
	input cache_line_pkg::line_addr_t req_addr,
	input cache_line_pkg::line_data_t req_wdata,
	output logic req_credit,
	input logic resp_space,
	output logic ev_read,
	output logic ev_write,
	output cache_line_pkg::line_addr_t ev_addr,
	output cache_line_pkg::line_data_t ev_wdata,
	input logic ev_resp
);

	import cache_line_pkg::*;
	import flow_pkg::*;

	// Entry storage, payload only so no reset
	line_addr_t addr_mem [REQ_DEPTH];
	line_data_t data_mem [REQ_DEPTH];
	logic write_mem [REQ_DEPTH];	// 1 for a write (eviction), 0 for a line read

	logic [REQ_PTR_W-1:0] wr_ptr;	// Next free slot
	logic [REQ_PTR_W-1:0] rd_ptr;	// Head entry
	credit_cnt_t count;				// Entries held
	logic push;
	logic pop;
	logic head_valid;

	// Sender only sends while holding a credit, so there is always a free slot
	assign push = req_valid;
	assign head_valid = (count != '0);
	assign pop = ev_resp & head_valid;	// Eviction buffer finished the head

	// Head presented to the eviction buffer
	assign ev_write = head_valid & write_mem[rd_ptr];
	// A read waits until the response queue can take its data
	assign ev_read = head_valid & ~write_mem[rd_ptr] & resp_space;
	assign ev_addr = addr_mem[rd_ptr];
	assign ev_wdata = data_mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			addr_mem[wr_ptr] <= req_addr;
			data_mem[wr_ptr] <= req_wdata;
			write_mem[wr_ptr] <= req_write;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			req_credit <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;	// Wraps at REQ_DEPTH
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + credit_cnt_t'(1);
				2'b01: count <= count - credit_cnt_t'(1);
				default: count <= count;	// Both or neither, level unchanged
			endcase
			// One credit back per retired entry, a cycle after ev_resp
			req_credit <= pop;
		end
	end

endmodule : request_queue

//--- rtl/eviction_buffer.sv
`timescale 1ns/1ps

module eviction_buffer
(
	input logic clk,
	input logic reset,
	input logic ev_read,
	input logic ev_write,
	input cache_line_pkg::line_addr_t ev_addr,
	input cache_line_pkg::line_data_t ev_wdata,
	output logic ev_resp,
	output cache_line_pkg::line_data_t ev_rdata,
	output logic pmem_read,
	output logic pmem_write,
	output cache_line_pkg::line_addr_t pmem_addr,
	output cache_line_pkg::line_data_t pmem_wdata,
	input cache_line_pkg::line_data_t pmem_rdata,
	input logic pmem_resp
);

	import cache_line_pkg::*;

	typedef enum logic [1:0]
	{
		empty,			// Nothing parked
		delay,			// Line just parked, cache may still read it back
		full,			// Line parked and waiting for an idle request stream
		buffer_write	// Parked line being written back to memory
	} ev_state_t;

	ev_state_t state;
	ev_state_t next_state;

	line_addr_t buffer_addr;	// Address of the parked line
	line_data_t buffer_data;	// Parked line itself
	logic load_buffer;			// Capture ev_addr and ev_wdata
	logic wb_sel;				// Memory gets the parked line instead of the request
	logic read_sel;				// Read answered from the buffer instead of memory
	logic addr_match;

	assign addr_match = (buffer_addr == ev_addr);

	// Datapath muxes
	assign pmem_addr = wb_sel ? buffer_addr : ev_addr;
	assign pmem_wdata = wb_sel ? buffer_data : ev_wdata;
	assign ev_rdata = read_sel ? buffer_data : pmem_rdata;

	always_ff @(posedge clk)
	begin
		if (load_buffer)
		begin
			buffer_addr <= ev_addr;
			buffer_data <= ev_wdata;
		end
	end

	// Per state outputs
	always_comb
	begin
		load_buffer = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		ev_resp = 1'b0;
		wb_sel = 1'b0;
		read_sel = 1'b0;
		case (state)
			empty:
			begin
				if (ev_read)
				begin
					pmem_read = 1'b1;	// Nothing parked, go to memory
					ev_resp = pmem_resp;
				end
				else if (ev_write)
				begin
					load_buffer = 1'b1;	// Park the eviction, done at once
					ev_resp = 1'b1;
				end
			end
			delay:
			begin
				// Only a read of the parked line is served here, anything else waits for full
				if (ev_read && addr_match)
				begin
					read_sel = 1'b1;
					ev_resp = 1'b1;
				end
			end
			full:
			begin
				if (ev_read && addr_match)
				begin
					read_sel = 1'b1;	// Hit on parked line, no memory access
					ev_resp = 1'b1;
				end
				else if (ev_read)
				begin
					pmem_read = 1'b1;
					ev_resp = pmem_resp;
				end
				else if (ev_write && addr_match)
				begin
					// Newer copy of the parked line replaces it, the later writeback stays current
					load_buffer = 1'b1;
					ev_resp = 1'b1;
				end
				else if (ev_write)
				begin
					pmem_write = 1'b1;	// Other line, bypass straight to memory
					ev_resp = pmem_resp;
				end
			end
			buffer_write:
			begin
				pmem_write = 1'b1;		// Writeback of parked line, no request is answered
				wb_sel = 1'b1;
			end
			default:
			begin
				load_buffer = 1'b0;
			end
		endcase
	end

	always_comb
	begin
		next_state = state;
		case (state)
			empty:
				if (ev_write && !ev_read)
					next_state = delay;
			delay:
				next_state = full;		// Exactly one cycle
			full:
				if (!ev_read && !ev_write)
					next_state = buffer_write;	// Request stream idle, start writeback
			buffer_write:
				if (pmem_resp)
					next_state = empty;
			default:
				next_state = empty;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= empty;
		else
			state <= next_state;
	end

endmodule : eviction_buffer

//--- rtl/response_queue.sv
`timescale 1ns/1ps

module response_queue
(
	input logic clk,
	input logic reset,
	input logic push,
	input cache_line_pkg::line_data_t push_data,
	output logic resp_space,
	output logic resp_valid,
	output cache_line_pkg::line_data_t resp_rdata,
	input logic resp_credit
);

	import cache_line_pkg::*;
	import flow_pkg::*;

	line_data_t data_mem [RESP_DEPTH];	// Read data waiting for the consumer

	logic [RESP_PTR_W-1:0] wr_ptr;
	logic [RESP_PTR_W-1:0] rd_ptr;
	credit_cnt_t count;		// Entries held
	credit_cnt_t credits;	// Consumer credits on hand
	logic pop;

	// Show the head only while the consumer has room for it
	assign pop = (count != '0) && (credits != '0);
	assign resp_valid = pop;
	assign resp_rdata = data_mem[rd_ptr];

	// Room if not full, or if the head leaves this cycle
	assign resp_space = (count != credit_cnt_t'(RESP_DEPTH)) || pop;

	always_ff @(posedge clk)
	begin
		if (push)
			data_mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credits <= credit_cnt_t'(RESP_CREDITS);	// Consumer grants a starting window
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + credit_cnt_t'(1);
				2'b01: count <= count - credit_cnt_t'(1);
				default: count <= count;
			endcase
			// Returned credit and spent credit can cancel in one cycle
			case ({resp_credit, pop})
				2'b10: credits <= credits + credit_cnt_t'(1);
				2'b01: credits <= credits - credit_cnt_t'(1);
				default: credits <= credits;
			endcase
		end
	end

endmodule : response_queue

//--- rtl/writeback_path_top.sv
`timescale 1ns/1ps

module writeback_path_top
(
	input logic clk,
	input logic reset,
	// Upstream cache controller
	input logic req_valid,
	input logic req_write,
	input cache_line_pkg::line_addr_t req_addr,
	input cache_line_pkg::line_data_t req_wdata,
	output logic req_credit,
	// Consumer of read data
	output logic resp_valid,
	output cache_line_pkg::line_data_t resp_rdata,
	input logic resp_credit,
	// Physical memory
	output logic pmem_read,
	output logic pmem_write,
	output cache_line_pkg::line_addr_t pmem_addr,
	output cache_line_pkg::line_data_t pmem_wdata,
	input cache_line_pkg::line_data_t pmem_rdata,
	input logic pmem_resp
);

	import cache_line_pkg::*;

	logic ev_read;
	logic ev_write;
	line_addr_t ev_addr;
	line_data_t ev_wdata;
	logic ev_resp;
	line_data_t ev_rdata;
	logic resp_space;	// Response queue can take one more line
	logic resp_push;

	// Only a finished read carries data into the response queue
	assign resp_push = ev_resp & ev_read;

	request_queue request_queue_inst
	(
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req_write(req_write),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.req_credit(req_credit),
		.resp_space(resp_space),
		.ev_read(ev_read),
		.ev_write(ev_write),
		.ev_addr(ev_addr),
		.ev_wdata(ev_wdata),
		.ev_resp(ev_resp)
	);

	eviction_buffer eviction_buffer_inst
	(
		.clk(clk),
		.reset(reset),
		.ev_read(ev_read),
		.ev_write(ev_write),
		.ev_addr(ev_addr),
		.ev_wdata(ev_wdata),
		.ev_resp(ev_resp),
		.ev_rdata(ev_rdata),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.pmem_addr(pmem_addr),
		.pmem_wdata(pmem_wdata),
		.pmem_rdata(pmem_rdata),
		.pmem_resp(pmem_resp)
	);

	response_queue response_queue_inst
	(
		.clk(clk),
		.reset(reset),
		.push(resp_push),
		.push_data(ev_rdata),
		.resp_space(resp_space),
		.resp_valid(resp_valid),
		.resp_rdata(resp_rdata),
		.resp_credit(resp_credit)
	);

endmodule : writeback_path_top

//--- tb/writeback_path_checker.sv
`timescale 1ns/1ps

module writeback_path_checker
(
	input logic clk,
	input logic reset,
	input logic req_valid,
	input logic req_write,
	input cache_line_pkg::line_addr_t req_addr,
	input cache_line_pkg::line_data_t req_wdata,
	input logic req_credit,
	input logic resp_valid,
	input cache_line_pkg::line_data_t resp_rdata,
	input logic resp_credit,
	input logic pmem_read,
	input logic pmem_write,
	input cache_line_pkg::line_addr_t pmem_addr,
	input cache_line_pkg::line_data_t pmem_wdata,
	input logic pmem_resp,
	input logic drain_done,		// Stimulus finished and memory traffic has stopped
	output int errors,
	output int checks,
	output logic report_done
);

	import cache_line_pkg::*;
	import flow_pkg::*;

	line_data_t exp_q[$];				// Expected read data, file order
	line_data_t shadow [line_addr_t];	// Latest write per address, as sent
	line_data_t mem_seen [line_addr_t];	// What actually reached memory
	int err_reset;
	int err_read;
	int err_mem;
	int err_credit;
	int err_flow;
	int sent;
	int returned;
	int shown;
	int credit_back;
	logic prev_reset;

	initial
	begin
		int fd;
		int n;
		string line;
		logic [7:0] kind;
		line_addr_t a;
		line_data_t d;
		int s;
		fd = $fopen("tb/writeback_vectors.txt", "r");
		if (fd != 0)
		begin
			while (!$feof(fd))
			begin
				line = "";
				n = $fgets(line, fd);
				// Only R lines carry a value to compare
				if (n > 1 && line.getc(0) == "R")
				begin
					n = $sscanf(line, "%c %h %h %d", kind, a, d, s);
					if (n == 4)
						exp_q.push_back(d);
				end
			end
			$fclose(fd);
		end
	end

	task automatic group_line(input string name, input int n);
		if (n == 0)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, n);
	endtask

	// Control output must be low on the first edge out of reset
	task automatic expect_low(input string name, input logic v);
		checks++;
		if (v !== 1'b0)
		begin
			err_reset++;
			$display("[FAIL] %0t %s expected 0 got %b", $time, name, v);
		end
	endtask

	task automatic final_compare();
		foreach (shadow[a])
		begin
			checks++;
			if (!mem_seen.exists(a))
			begin
				err_mem++;
				$display("Write to line %h never reached memory", a);
			end
			else if (mem_seen[a] !== shadow[a])
			begin
				err_mem++;
				$display("[FAIL] %0t mem[%h] expected %h got %h", $time, a, shadow[a], mem_seen[a]);
			end
		end
		checks++;
		if (sent != returned)
		begin
			err_credit++;
			$display("Sent %0d requests but got %0d credits back", sent, returned);
		end
		checks++;
		if (exp_q.size() != 0)
		begin
			err_flow++;
			$display("%0d read responses never arrived", exp_q.size());
		end
		group_line("reset state", err_reset);
		group_line("request credits", err_credit);
		group_line("read data", err_read);
		group_line("writeback", err_mem);
		group_line("response flow", err_flow);
		errors = err_reset + err_credit + err_read + err_mem + err_flow;
	endtask

	always @(posedge clk)
	begin
		prev_reset <= reset;
		if (reset)
		begin
			errors = 0;
			checks = 0;
			report_done <= 1'b0;
			err_reset = 0;
			err_read = 0;
			err_mem = 0;
			err_credit = 0;
			err_flow = 0;
			sent = 0;
			returned = 0;
			shown = 0;
			credit_back = 0;
		end
		else
		begin
			if (prev_reset)
			begin
				// First edge out of reset
				expect_low("req_credit", req_credit);
				expect_low("resp_valid", resp_valid);
				expect_low("pmem_read", pmem_read);
				expect_low("pmem_write", pmem_write);
			end
			if (req_valid)
			begin
				sent++;
				if (req_write)
					shadow[req_addr] = req_wdata;
			end
			if (req_credit)
				returned++;
			// A credit only comes back for a request already sent
			if (returned > sent)
			begin
				err_credit++;
				$display("More request credits returned than requests sent at %0t", $time);
			end
			if (resp_valid)
			begin
				shown++;
				checks++;
				// This cycle's returned credit is not usable yet
				if (shown > RESP_CREDITS + credit_back)
				begin
					err_flow++;
					$display("Response shown without a consumer credit at %0t", $time);
				end
				if (exp_q.size() == 0)
				begin
					err_flow++;
					$display("Extra response with no read outstanding at %0t", $time);
				end
				else
				begin
					if (resp_rdata !== exp_q[0])
					begin
						err_read++;
						$display("[FAIL] %0t resp_rdata expected %h got %h", $time, exp_q[0],
							resp_rdata);
					end
					void'(exp_q.pop_front());
				end
			end
			if (resp_credit)
				credit_back++;
			if (pmem_write && pmem_resp)
				mem_seen[pmem_addr] = pmem_wdata;	// Memory takes it in the resp cycle
			if (drain_done && !report_done)
			begin
				final_compare();
				report_done <= 1'b1;
			end
		end
	end

endmodule : writeback_path_checker

//--- tb/writeback_path_tb.sv
`timescale 1ns/1ps

module writeback_path_tb;

	import cache_line_pkg::*;
	import flow_pkg::*;

	localparam int MEM_LAT = 2;		// Cycles from request to pmem_resp
	localparam int TIMEOUT = 2000;	// Cycles any single wait may take

	logic clk;
	logic reset;
	logic req_valid;
	logic req_write;
	line_addr_t req_addr;
	line_data_t req_wdata;
	logic req_credit;
	logic resp_valid;
	line_data_t resp_rdata;
	logic resp_credit;
	logic pmem_read;
	logic pmem_write;
	line_addr_t pmem_addr;
	line_data_t pmem_wdata;
	line_data_t pmem_rdata;
	logic pmem_resp;
	logic drain_done;
	logic report_done;
	int errors;
	int checks;

	logic [7:0] kind_q[$];
	line_addr_t addr_q[$];
	line_data_t data_q[$];
	int stall_q[$];
	int rd_stall[$];		// Consumer stall per read, in order
	int due_q[$];			// Cycles at which a credit goes back
	line_data_t mem [line_addr_t];
	int lat;
	int cyc;
	int sent;
	int returned;
	int rsp_seen;
	logic aborted;			// A wait timed out or the vectors could not be read
	string abort_msg;

	writeback_path_top writeback_path_top_inst
	(
		.clk(clk), .reset(reset),
		.req_valid(req_valid), .req_write(req_write), .req_addr(req_addr),
		.req_wdata(req_wdata), .req_credit(req_credit),
		.resp_valid(resp_valid), .resp_rdata(resp_rdata), .resp_credit(resp_credit),
		.pmem_read(pmem_read), .pmem_write(pmem_write), .pmem_addr(pmem_addr),
		.pmem_wdata(pmem_wdata), .pmem_rdata(pmem_rdata), .pmem_resp(pmem_resp)
	);

	writeback_path_checker checker_inst
	(
		.clk(clk), .reset(reset),
		.req_valid(req_valid), .req_write(req_write), .req_addr(req_addr),
		.req_wdata(req_wdata), .req_credit(req_credit),
		.resp_valid(resp_valid), .resp_rdata(resp_rdata), .resp_credit(resp_credit),
		.pmem_read(pmem_read), .pmem_write(pmem_write), .pmem_addr(pmem_addr),
		.pmem_wdata(pmem_wdata), .pmem_resp(pmem_resp),
		.drain_done(drain_done), .errors(errors), .checks(checks), .report_done(report_done)
	);

	always #50 clk = ~clk;	// 100 ns period

	// Record why the run stops early
	task automatic flag_abort(input string why);
		aborted = 1'b1;
		abort_msg = why;
	endtask

	task automatic load_vectors();
		int fd;
		int n;
		string line;
		logic [7:0] k;
		line_addr_t a;
		line_data_t d;
		int s;
		fd = $fopen("tb/writeback_vectors.txt", "r");
		if (fd == 0)
			flag_abort("Could not open tb/writeback_vectors.txt");
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				n = $fgets(line, fd);
				if (n > 1 && line.getc(0) != "#")	// Skip comments and blank lines
				begin
					n = $sscanf(line, "%c %h %h %d", k, a, d, s);
					if (n == 4)
					begin
						kind_q.push_back(k);
						addr_q.push_back(a);
						data_q.push_back(d);
						stall_q.push_back(s);
						if (k == "R")
							rd_stall.push_back(s);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// Called just after a rising edge, returns just after the edge that took the request
	task automatic send_req(input logic w, input line_addr_t a, input line_data_t d);
		int waited;
		waited = 0;
		while (sent - returned >= REQ_DEPTH && waited <= TIMEOUT)
		begin
			req_valid <= 1'b0;	// Out of credits, hold off
			@(posedge clk);
			waited++;
		end
		if (sent - returned >= REQ_DEPTH)
			flag_abort("Timed out waiting for a request credit");
		else
		begin
			req_valid <= 1'b1;
			req_write <= w;
			req_addr <= a;
			req_wdata <= d;
			sent++;
			@(posedge clk);
		end
	endtask

	// Memory model, fixed latency, unwritten lines read as their address repeated
	always @(posedge clk)
	begin
		if (reset || pmem_resp)
		begin
			pmem_resp <= 1'b0;
			lat = 0;
		end
		else if (pmem_read || pmem_write)
		begin
			if (lat == MEM_LAT - 1)
			begin
				pmem_resp <= 1'b1;
				if (pmem_write)
					mem[pmem_addr] = pmem_wdata;
				else
					pmem_rdata <= mem.exists(pmem_addr) ? mem[pmem_addr] : {8{pmem_addr}};
			end
			else
				lat++;
		end
	end

	// Request credits counted mid cycle where req_credit is stable
	always @(negedge clk)
	begin
		if (!reset && req_credit)
			returned++;
	end

	// Consumer, one credit back per response after its stall
	always @(posedge clk)
	begin
		logic found;
		found = 1'b0;
		resp_credit <= 1'b0;
		cyc++;
		if (!reset)
		begin
			if (resp_valid)
			begin
				due_q.push_back(cyc + ((rsp_seen < rd_stall.size()) ? rd_stall[rsp_seen] : 0));
				rsp_seen++;
			end
			for (int i = 0; i < due_q.size(); i++)
			begin
				if (!found && due_q[i] <= cyc)
				begin
					found = 1'b1;	// Only one credit pulse per cycle
					due_q.delete(i);
				end
			end
			if (found)
				resp_credit <= 1'b1;
		end
	end

	initial
	begin
		int waited;
		int quiet;
		int n_reads;
		clk = 1'b0;
		reset = 1'b1;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		resp_credit = 1'b0;
		pmem_rdata = '0;
		pmem_resp = 1'b0;
		drain_done = 1'b0;
		lat = 0;
		cyc = 0;
		sent = 0;
		returned = 0;
		rsp_seen = 0;
		aborted = 1'b0;
		abort_msg = "";
		load_vectors();
		n_reads = rd_stall.size();
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		for (int i = 0; i < kind_q.size() && !aborted; i++)
		begin
			if (kind_q[i] == "W" || kind_q[i] == "R")
				send_req(kind_q[i] == "W", addr_q[i], data_q[i]);
			else
			begin
				req_valid <= 1'b0;
				repeat (stall_q[i]) @(posedge clk);	// Idle line, stall column is the length
			end
		end
		req_valid <= 1'b0;
		// Drain until every credit and response is back and memory stays quiet
		waited = 0;
		quiet = 0;
		while (!aborted && quiet < 8)
		begin
			@(posedge clk);
			if (sent == returned && rsp_seen == n_reads && !pmem_read && !pmem_write)
				quiet++;
			else
				quiet = 0;
			waited++;
			if (waited > TIMEOUT)
				flag_abort("Drain did not finish, requests or writebacks still pending");
		end
		if (!aborted)
			drain_done <= 1'b1;
		waited = 0;
		while (!aborted && !report_done)
		begin
			@(posedge clk);
			waited++;
			if (waited > TIMEOUT)
				flag_abort("Checker never finished its final report");
		end
		if (aborted)
			$display("%s", abort_msg);
		else
			$display("checks %0d, errors %0d", checks, errors);
		if (!aborted && errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule : writeback_path_tb

//--- tb/writeback_vectors.txt
# kind(W write, R read, I idle) addr(hex) data(hex, write data or expected read) stall(dec)
# stall is the consumer delay for R and the idle length for I
I 0000 00000000000000000000000000000000 4
W 0100 0123456789abcdef0011223344556677 0
R 0100 0123456789abcdef0011223344556677 0
I 0000 00000000000000000000000000000000 10
W 0200 deadbeefcafef00d1122334455667788 0
R 0300 03000300030003000300030003000300 0
R 0200 deadbeefcafef00d1122334455667788 0
W 0200 0f1e2d3c4b5a69788796a5b4c3d2e1f0 0
W 0400 a5a5a5a55a5a5a5a0000ffff1234abcd 0
R 0200 0f1e2d3c4b5a69788796a5b4c3d2e1f0 0
R 0400 a5a5a5a55a5a5a5a0000ffff1234abcd 0
I 0000 00000000000000000000000000000000 10
R 0200 0f1e2d3c4b5a69788796a5b4c3d2e1f0 0
W 0500 13572468ace0bdf102468ace13579bdf 0
I 0000 00000000000000000000000000000000 10
R 0500 13572468ace0bdf102468ace13579bdf 12
R 0600 06000600060006000600060006000600 12
R 0700 07000700070007000700070007000700 0
W 0800 ffeeddccbbaa99887766554433221100 0
R 0500 13572468ace0bdf102468ace13579bdf 0
R 0100 0123456789abcdef0011223344556677 0
R 0800 ffeeddccbbaa99887766554433221100 3
I 0000 00000000000000000000000000000000 20

//--- sources.f
rtl/cache_line_pkg.sv
rtl/flow_pkg.sv
rtl/request_queue.sv
rtl/eviction_buffer.sv
rtl/response_queue.sv
rtl/writeback_path_top.sv
tb/writeback_path_checker.sv
tb/writeback_path_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module writeback_path_tb -o writeback_sim

output=$(./obj_dir/writeback_sim)
echo "$output"

if echo "$output" | grep -q "Everything OK"; then
	exit 0
else
	exit 1
fi
